// ==== verilog/rtf_isa_pkg.sv ====
`default_nettype none

package rtf_isa_pkg;

	// --------------------------------------------------
	// instruction bytes, anything not listed is a no-op
	// --------------------------------------------------
	typedef enum logic [7:0] {
		RR      = 8'h02,	// register to register, fn selects the operation
		ADD_IMM = 8'h69,
		SUB_IMM = 8'hE9,
		AND_IMM = 8'h29,
		OR_IMM  = 8'h09,
		EOR_IMM = 8'h49,
		LD_IMM  = 8'hA9,
		BEQ     = 8'hF0,
		BNE     = 8'hD0,
		BPL     = 8'h10,
		BMI     = 8'h30,
		BCS     = 8'hB0,
		BCC     = 8'h90,
		BVS     = 8'h70,
		BVC     = 8'h50,
		BRA     = 8'h80,
		BHI     = 8'h13,	// unsigned compare group
		BLS     = 8'h33,
		BGE     = 8'h93,	// signed compare group
		BLT     = 8'hB3,
		BGT     = 8'hD3,
		BLE     = 8'hF3
	} opcode_e;

	// function codes of the RR opcode
	typedef enum logic [3:0] {
		FN_ADD = 4'h0,
		FN_SUB = 4'h1,
		FN_AND = 4'h3,
		FN_EOR = 4'h4,
		FN_OR  = 4'h5
	} rr_fn_e;

	// --------------------------------------------------
	// instruction formats, opcode in the low byte
	// --------------------------------------------------
	typedef struct packed {
		logic [7:0] unused;
		logic [3:0] fn;
		logic [3:0] rt;
		logic [3:0] rb;
		logic [3:0] ra;
		logic [7:0] opcode;
	} rr_fmt_t;

	typedef struct packed {
		logic [15:0] imm;	// zero-extended on use
		logic [3:0]  rt;	// same position as rb in the RR format
		logic [3:0]  ra;
		logic [7:0]  opcode;
	} imm_fmt_t;

	typedef struct packed {
		logic [15:0] unused;
		logic [7:0]  disp;	// signed word count
		logic [7:0]  opcode;
	} br_fmt_t;

	// one word, read by whichever format its opcode implies
	typedef union packed {
		rr_fmt_t  rr;
		imm_fmt_t imm;
		br_fmt_t  br;
	} insn_u;

endpackage

`default_nettype wire

// ==== verilog/rtf_core_pkg.sv ====
`default_nettype none

package rtf_core_pkg;

	// committed condition flags
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// --------------------------------------------------
	// execute stage records
	// --------------------------------------------------
	typedef struct packed {
		logic               valid;
		rtf_isa_pkg::insn_u insn;
		logic [31:0]        a;	// value of ra
		logic [31:0]        b;	// value of rb, rt for the immediate format
	} operand_t;

	typedef struct packed {
		logic        wr;
		logic [3:0]  rt;
		logic [31:0] data;
		logic        flags_upd;
		flags_t      flags;
	} alu_res_t;

	typedef struct packed {
		logic       taken;
		logic [7:0] disp;
	} br_res_t;

	// register file write port
	typedef struct packed {
		logic        en;
		logic [3:0]  rt;
		logic [31:0] data;
	} rf_wr_t;

	typedef struct packed {
		logic        valid;
		logic        wr;
		logic [3:0]  rt;
		logic [31:0] data;
		logic [31:0] pc;	// address of the committed instruction
	} commit_t;

endpackage

`default_nettype wire

// ==== verilog/rtf_operand_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_operand_stage (
	input  wire                      clk,
	input  wire                      rst_i,
	input  rtf_isa_pkg::insn_u       insn_i,
	input  wire                      insn_valid_i,
	input  rtf_core_pkg::rf_wr_t     rf_wr_i,
	output rtf_core_pkg::operand_t   operands_o
);

	logic               stage_valid;
	rtf_isa_pkg::insn_u stage_insn;
	logic [31:0]        regs [16];
	logic [3:0]         ra;
	logic [3:0]         rb;

	// --------------------------------------------------
	// stage register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i)
			stage_valid <= 1'b0;
		else
			stage_valid <= insn_valid_i;
	end

	always_ff @(posedge clk) begin
		stage_insn <= insn_i;	// payload, qualified by stage_valid
	end

	// --------------------------------------------------
	// register file, one write port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 32'd0;
		end
		else if (rf_wr_i.en && rf_wr_i.rt != 4'd0) begin
			regs[rf_wr_i.rt] <= rf_wr_i.data;
		end
	end

	// register fields come from the RR view whatever the format
	assign ra = stage_insn.rr.ra;
	assign rb = stage_insn.rr.rb;

	always_comb begin
		operands_o.valid = stage_valid;
		operands_o.insn  = stage_insn;
		operands_o.a     = (ra == 4'd0) ? 32'd0 : regs[ra];	// r0 reads zero
		operands_o.b     = (rb == 4'd0) ? 32'd0 : regs[rb];
	end

endmodule

`default_nettype wire

// ==== verilog/rtf_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_alu (
	input  rtf_core_pkg::operand_t operands_i,
	input  rtf_core_pkg::flags_t   flags_i,
	output rtf_core_pkg::alu_res_t alu_res_o
);

	logic        op_add;
	logic        op_sub;
	logic        op_and;
	logic        op_or;
	logic        op_eor;
	logic        op_ld;
	logic        op_any;
	logic        is_imm;
	logic [31:0] opa;
	logic [31:0] opb;
	logic [3:0]  rt_sel;
	logic [32:0] sum;
	logic [32:0] dif;
	logic [31:0] res;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	always_comb begin
		op_add = 1'b0;
		op_sub = 1'b0;
		op_and = 1'b0;
		op_or  = 1'b0;
		op_eor = 1'b0;
		op_ld  = 1'b0;
		case (operands_i.insn.rr.opcode)
		rtf_isa_pkg::RR:
			case (operands_i.insn.rr.fn)
			rtf_isa_pkg::FN_ADD: op_add = 1'b1;
			rtf_isa_pkg::FN_SUB: op_sub = 1'b1;
			rtf_isa_pkg::FN_AND: op_and = 1'b1;
			rtf_isa_pkg::FN_OR:  op_or  = 1'b1;
			rtf_isa_pkg::FN_EOR: op_eor = 1'b1;
			default: ;	// unknown function is a no-op
			endcase
		rtf_isa_pkg::ADD_IMM: op_add = 1'b1;
		rtf_isa_pkg::SUB_IMM: op_sub = 1'b1;
		rtf_isa_pkg::AND_IMM: op_and = 1'b1;
		rtf_isa_pkg::OR_IMM:  op_or  = 1'b1;
		rtf_isa_pkg::EOR_IMM: op_eor = 1'b1;
		rtf_isa_pkg::LD_IMM:  op_ld  = 1'b1;
		default: ;	// branches and unknown bytes
		endcase
	end

	assign op_any = op_add | op_sub | op_and | op_or | op_eor | op_ld;
	assign is_imm = operands_i.insn.rr.opcode != rtf_isa_pkg::RR;

	// second operand is the immediate outside the RR format
	assign opa    = operands_i.a;
	assign opb    = is_imm ? {16'h0000, operands_i.insn.imm.imm} : operands_i.b;
	assign rt_sel = is_imm ? operands_i.insn.imm.rt : operands_i.insn.rr.rt;

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	assign sum = {1'b0, opa} + {1'b0, opb};
	assign dif = {1'b0, opa} + {1'b0, ~opb} + 33'd1;	// bit 32 is not-borrow

	always_comb begin
		res = 32'd0;
		if (op_add)
			res = sum[31:0];
		else if (op_sub)
			res = dif[31:0];
		else if (op_and)
			res = opa & opb;
		else if (op_or)
			res = opa | opb;
		else if (op_eor)
			res = opa ^ opb;
		else if (op_ld)
			res = opb;
	end

	// --------------------------------------------------
	// result and flags
	// --------------------------------------------------
	always_comb begin
		alu_res_o.wr        = op_any && rt_sel != 4'd0;	// r0 is never written
		alu_res_o.rt        = rt_sel;
		alu_res_o.data      = res;
		alu_res_o.flags_upd = op_any;
		alu_res_o.flags.n   = res[31];
		alu_res_o.flags.z   = res == 32'd0;
		alu_res_o.flags.c   = flags_i.c;	// logic ops and loads keep c and v
		alu_res_o.flags.v   = flags_i.v;
		if (op_add) begin
			alu_res_o.flags.c = sum[32];
			alu_res_o.flags.v = (opa[31] == opb[31]) && (res[31] != opa[31]);
		end
		else if (op_sub) begin
			alu_res_o.flags.c = dif[32];
			alu_res_o.flags.v = (opa[31] != opb[31]) && (res[31] != opa[31]);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rtf_branch_eval.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_branch_eval (
	input  rtf_core_pkg::operand_t operands_i,
	input  rtf_core_pkg::flags_t   flags_i,
	output rtf_core_pkg::br_res_t  br_res_o
);

	logic n;
	logic z;
	logic c;
	logic v;
	logic takb;

	assign n = flags_i.n;
	assign z = flags_i.z;
	assign c = flags_i.c;
	assign v = flags_i.v;

	// --------------------------------------------------
	// condition table
	// --------------------------------------------------
	always_comb begin
		case (operands_i.insn.br.opcode)
		rtf_isa_pkg::BEQ: takb = z;
		rtf_isa_pkg::BNE: takb = !z;
		rtf_isa_pkg::BPL: takb = !n;
		rtf_isa_pkg::BMI: takb = n;
		rtf_isa_pkg::BCS: takb = c;
		rtf_isa_pkg::BCC: takb = !c;
		rtf_isa_pkg::BVS: takb = v;
		rtf_isa_pkg::BVC: takb = !v;
		rtf_isa_pkg::BRA: takb = 1'b1;
		rtf_isa_pkg::BHI: takb = c & !z;	// unsigned higher
		rtf_isa_pkg::BLS: takb = !c | z;
		rtf_isa_pkg::BGE: takb = n == v;	// signed, n and v agree
		rtf_isa_pkg::BLT: takb = n != v;
		rtf_isa_pkg::BGT: takb = !z && (n == v);
		rtf_isa_pkg::BLE: takb = z || (n != v);
		default:          takb = 1'b0;	// not a branch
		endcase
	end

	// the displacement travels with the taken bit to the pc update
	assign br_res_o.taken = operands_i.valid & takb;
	assign br_res_o.disp  = operands_i.insn.br.disp;

endmodule

`default_nettype wire

// ==== verilog/rtf_commit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_commit #(
	parameter logic [31:0] RESET_PC = 32'd0
) (
	input  wire                      clk,
	input  wire                      rst_i,
	input  rtf_core_pkg::operand_t   operands_i,
	input  rtf_core_pkg::alu_res_t   alu_res_i,
	input  rtf_core_pkg::br_res_t    br_res_i,
	output rtf_core_pkg::rf_wr_t     rf_wr_o,
	output rtf_core_pkg::flags_t     flags_o,
	output logic [31:0]              pc_o,
	output rtf_core_pkg::commit_t    commit_o
);

	logic [31:0]          pc;
	logic [31:0]          pc_next;
	logic [31:0]          br_ofs;
	rtf_core_pkg::flags_t flags;

	// --------------------------------------------------
	// next pc
	// --------------------------------------------------
	assign br_ofs  = {{22{br_res_i.disp[7]}}, br_res_i.disp, 2'b00};	// words to bytes
	assign pc_next = pc + 32'd4 + (br_res_i.taken ? br_ofs : 32'd0);

	// register write-back goes straight to the file, written at the edge
	always_comb begin
		rf_wr_o.en   = operands_i.valid & alu_res_i.wr;
		rf_wr_o.rt   = alu_res_i.rt;
		rf_wr_o.data = alu_res_i.data;
	end

	// --------------------------------------------------
	// architectural state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc    <= RESET_PC;
			flags <= '0;
		end
		else if (operands_i.valid) begin
			pc <= pc_next;
			if (alu_res_i.flags_upd)
				flags <= alu_res_i.flags;
		end
	end

	// commit record, valid for one cycle per instruction
	always_ff @(posedge clk) begin
		if (rst_i) begin
			commit_o.valid <= 1'b0;
			commit_o.wr    <= 1'b0;
		end
		else begin
			commit_o.valid <= operands_i.valid;
			commit_o.wr    <= operands_i.valid & alu_res_i.wr;
		end
	end

	always_ff @(posedge clk) begin
		if (operands_i.valid) begin
			commit_o.rt   <= alu_res_i.rt;
			commit_o.data <= alu_res_i.data;
			commit_o.pc   <= pc;	// pc of the instruction itself
		end
	end

	assign flags_o = flags;
	assign pc_o    = pc;

endmodule

`default_nettype wire

// ==== verilog/rtf_exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_exec_top #(
	parameter logic [31:0] RESET_PC = 32'd0
) (
	input  wire                      clk,
	input  wire                      rst_i,
	input  rtf_isa_pkg::insn_u       insn_i,
	input  wire                      insn_valid_i,
	output rtf_core_pkg::commit_t    commit_o,
	output rtf_core_pkg::flags_t     flags_o,
	output logic [31:0]              pc_o
);

	rtf_core_pkg::operand_t operands;
	rtf_core_pkg::alu_res_t alu_res;
	rtf_core_pkg::br_res_t  br_res;
	rtf_core_pkg::rf_wr_t   rf_wr;

	// --------------------------------------------------
	// operand read, then alu and branch side by side
	// --------------------------------------------------
	rtf_operand_stage u_opstage (
		.clk          (clk),
		.rst_i        (rst_i),
		.insn_i       (insn_i),
		.insn_valid_i (insn_valid_i),
		.rf_wr_i      (rf_wr),
		.operands_o   (operands)
	);

	rtf_alu u_alu (
		.operands_i (operands),
		.flags_i    (flags_o),
		.alu_res_o  (alu_res)
	);

	rtf_branch_eval u_breval (
		.operands_i (operands),
		.flags_i    (flags_o),	// committed flags
		.br_res_o   (br_res)
	);

	// commit closes the loop back to the register file
	rtf_commit #(
		.RESET_PC (RESET_PC)
	) u_commit (
		.clk        (clk),
		.rst_i      (rst_i),
		.operands_i (operands),
		.alu_res_i  (alu_res),
		.br_res_i   (br_res),
		.rf_wr_o    (rf_wr),
		.flags_o    (flags_o),
		.pc_o       (pc_o),
		.commit_o   (commit_o)
	);

endmodule

`default_nettype wire

// ==== dv/rtf_exec_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rtf_exec_tb;

	typedef struct packed {
		logic                  vld;
		rtf_isa_pkg::insn_u    insn;
		rtf_core_pkg::commit_t exp_commit;
		rtf_core_pkg::flags_t  exp_flags;
		logic [31:0]           exp_pc;	// pc_o once the entry has committed
	} case_t;

	logic                  clk = 1'b0;
	logic                  rst_i;
	rtf_isa_pkg::insn_u    insn_i;
	logic                  insn_valid_i;
	rtf_core_pkg::commit_t commit_o;
	rtf_core_pkg::flags_t  flags_o;
	logic [31:0]           pc_o;

	case_t       cases[$];
	string       names[$];
	logic [31:0] next_pc;	// running model of the fetch address
	int          table_len;
	int          commit_errs;
	int          flag_errs;
	int          pc_errs;

	rtf_exec_top #(
		.RESET_PC (32'd0)
	) dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.insn_i       (insn_i),
		.insn_valid_i (insn_valid_i),
		.commit_o     (commit_o),
		.flags_o      (flags_o),
		.pc_o         (pc_o)
	);

	always #2 clk = ~clk;

	// --------------------------------------------------
	// instruction encoding
	// --------------------------------------------------
	function automatic rtf_isa_pkg::insn_u rr_op(input rtf_isa_pkg::rr_fn_e fn,
			input logic [3:0] rt, input logic [3:0] ra, input logic [3:0] rb);
		return {8'h00, fn, rt, rb, ra, rtf_isa_pkg::RR};
	endfunction

	function automatic rtf_isa_pkg::insn_u ld_imm(input logic [3:0] rt, input logic [15:0] imm);
		return {imm, rt, 4'h0, rtf_isa_pkg::LD_IMM};
	endfunction

	function automatic rtf_isa_pkg::insn_u br_op(input rtf_isa_pkg::opcode_e op,
			input logic [7:0] disp);
		return {16'h0000, disp, op};
	endfunction

	// --------------------------------------------------
	// table entries
	// --------------------------------------------------
	task automatic add_case(input string name, input rtf_isa_pkg::insn_u insn, input logic wr,
			input logic [3:0] rt, input logic [31:0] data, input rtf_core_pkg::flags_t fl,
			input int jump);
		case_t c;
		c.vld        = 1'b1;
		c.insn       = insn;
		c.exp_commit = {1'b1, wr, rt, data, next_pc};
		c.exp_flags  = fl;
		next_pc      = next_pc + 32'd4 + 32'(jump * 4);	// jump is the taken word offset
		c.exp_pc     = next_pc;
		cases.push_back(c);
		names.push_back(name);
	endtask

	task automatic add_idle(input string name, input rtf_core_pkg::flags_t fl);
		case_t c;
		c           = '0;
		c.exp_flags = fl;
		c.exp_pc    = next_pc;	// no commit so the pc holds
		cases.push_back(c);
		names.push_back(name);
	endtask

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	function automatic string fmt_commit(input rtf_core_pkg::commit_t c);
		return $sformatf("v=%b wr=%b rt=%0d data=%h pc=%h", c.valid, c.wr, c.rt, c.data, c.pc);
	endfunction

	task automatic check_commit(input string name, input rtf_core_pkg::commit_t exp,
			input rtf_core_pkg::commit_t act);
		logic bad;
		bad = (act.valid !== exp.valid) || (act.wr !== exp.wr);
		if (exp.valid && act.pc !== exp.pc)
			bad = 1'b1;
		if (exp.wr && (act.rt !== exp.rt || act.data !== exp.data))
			bad = 1'b1;	// rt and data only mean something on a write
		if (bad) begin
			commit_errs++;
			$display("Fail %s commit: expected %s actual %s", name, fmt_commit(exp),
				fmt_commit(act));
		end
	endtask

	task automatic check_flags(input string name, input rtf_core_pkg::flags_t exp,
			input rtf_core_pkg::flags_t act);
		if (act !== exp) begin
			flag_errs++;
			$display("Fail %s flags: expected nzcv=%b actual nzcv=%b", name, exp, act);
		end
	endtask

	task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			pc_errs++;
			$display("Fail %s pc: expected %h actual %h", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// stimulus and expected results
	// --------------------------------------------------
	task automatic build_table();
		logic [3:0] src;
		add_case("ld_r1", ld_imm(1, 16'hffff), 1, 1, 32'h0000ffff, 4'b0000, 0);
		add_case("ld_r2", ld_imm(2, 16'h0001), 1, 2, 32'h00000001, 4'b0000, 0);
		add_case("ld_r3", ld_imm(3, 16'h7fff), 1, 3, 32'h00007fff, 4'b0000, 0);
		add_case("ld_r4", ld_imm(4, 16'h8000), 1, 4, 32'h00008000, 4'b0000, 0);
		add_case("sub_r0", rr_op(rtf_isa_pkg::FN_SUB, 5, 0, 2), 1, 5, 32'hffffffff, 4'b1000, 0);
		add_case("add_carry", rr_op(rtf_isa_pkg::FN_ADD, 6, 5, 2), 1, 6, 32'h0, 4'b0110, 0);
		add_case("sub_eq", rr_op(rtf_isa_pkg::FN_SUB, 7, 1, 1), 1, 7, 32'h0, 4'b0110, 0);
		add_case("eor_rr", rr_op(rtf_isa_pkg::FN_EOR, 8, 5, 1), 1, 8, 32'hffff0000, 4'b1010, 0);
		add_case("and_zero", rr_op(rtf_isa_pkg::FN_AND, 9, 8, 1), 1, 9, 32'h0, 4'b0110, 0);
		add_case("or_rr", rr_op(rtf_isa_pkg::FN_OR, 9, 3, 4), 1, 9, 32'h0000ffff, 4'b0010, 0);
		add_case("wr_r0", rr_op(rtf_isa_pkg::FN_ADD, 0, 1, 2), 0, 0, 32'h00010000, 4'b0000, 0);
		add_case("or_keep_c", rr_op(rtf_isa_pkg::FN_OR, 10, 1, 2), 1, 10, 32'h0000ffff, 4'b0000, 0);
		// all flags clear
		add_case("beq_nt", br_op(rtf_isa_pkg::BEQ, 8'h03), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bne_t", br_op(rtf_isa_pkg::BNE, 8'h02), 0, 0, 32'h0, 4'b0000, 2);
		add_case("bpl_t", br_op(rtf_isa_pkg::BPL, 8'hfe), 0, 0, 32'h0, 4'b0000, -2);
		add_case("bmi_nt", br_op(rtf_isa_pkg::BMI, 8'h05), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bcs_nt", br_op(rtf_isa_pkg::BCS, 8'h05), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bcc_t", br_op(rtf_isa_pkg::BCC, 8'h01), 0, 0, 32'h0, 4'b0000, 1);
		add_case("bvs_nt", br_op(rtf_isa_pkg::BVS, 8'h07), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bvc_t", br_op(rtf_isa_pkg::BVC, 8'hf0), 0, 0, 32'h0, 4'b0000, -16);
		add_case("bra_t", br_op(rtf_isa_pkg::BRA, 8'h7f), 0, 0, 32'h0, 4'b0000, 127);
		add_case("bhi_nt", br_op(rtf_isa_pkg::BHI, 8'h04), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bls_t", br_op(rtf_isa_pkg::BLS, 8'h03), 0, 0, 32'h0, 4'b0000, 3);
		add_case("bge_t", br_op(rtf_isa_pkg::BGE, 8'h04), 0, 0, 32'h0, 4'b0000, 4);
		add_case("blt_nt", br_op(rtf_isa_pkg::BLT, 8'h04), 0, 0, 32'h0, 4'b0000, 0);
		add_case("bgt_t", br_op(rtf_isa_pkg::BGT, 8'h06), 0, 0, 32'h0, 4'b0000, 6);
		add_case("ble_nt", br_op(rtf_isa_pkg::BLE, 8'h06), 0, 0, 32'h0, 4'b0000, 0);
		// negative sum with carry sets n and c
		add_case("add_neg", rr_op(rtf_isa_pkg::FN_ADD, 11, 5, 8), 1, 11, 32'hfffeffff, 4'b1010, 0);
		add_case("bpl_nt", br_op(rtf_isa_pkg::BPL, 8'h02), 0, 0, 32'h0, 4'b1010, 0);
		add_case("bmi_t", br_op(rtf_isa_pkg::BMI, 8'h01), 0, 0, 32'h0, 4'b1010, 1);
		add_case("bcs_t", br_op(rtf_isa_pkg::BCS, 8'h02), 0, 0, 32'h0, 4'b1010, 2);
		add_case("bcc_nt", br_op(rtf_isa_pkg::BCC, 8'h02), 0, 0, 32'h0, 4'b1010, 0);
		add_case("bhi_t", br_op(rtf_isa_pkg::BHI, 8'h03), 0, 0, 32'h0, 4'b1010, 3);
		add_case("bls_nt", br_op(rtf_isa_pkg::BLS, 8'h03), 0, 0, 32'h0, 4'b1010, 0);
		add_case("bge_nt", br_op(rtf_isa_pkg::BGE, 8'h02), 0, 0, 32'h0, 4'b1010, 0);
		add_case("blt_t", br_op(rtf_isa_pkg::BLT, 8'hff), 0, 0, 32'h0, 4'b1010, -1);
		add_case("bgt_nt", br_op(rtf_isa_pkg::BGT, 8'h02), 0, 0, 32'h0, 4'b1010, 0);
		add_case("ble_t", br_op(rtf_isa_pkg::BLE, 8'h05), 0, 0, 32'h0, 4'b1010, 5);
		// r12 doubles each step, the last one overflows to zero
		for (int k = 1; k <= 16; k++) begin
			src = (k == 1) ? 4'd8 : 4'd12;
			add_case($sformatf("add_double_%0d", k), rr_op(rtf_isa_pkg::FN_ADD, 12, src, src),
				1, 12, 32'hffff0000 << k, (k < 16) ? 4'b1010 : 4'b0111, 0);
		end
		add_case("beq_t", br_op(rtf_isa_pkg::BEQ, 8'h02), 0, 0, 32'h0, 4'b0111, 2);
		add_case("bne_nt", br_op(rtf_isa_pkg::BNE, 8'h02), 0, 0, 32'h0, 4'b0111, 0);
		add_case("bvs_t", br_op(rtf_isa_pkg::BVS, 8'hfd), 0, 0, 32'h0, 4'b0111, -3);
		add_case("bvc_nt", br_op(rtf_isa_pkg::BVC, 8'h02), 0, 0, 32'h0, 4'b0111, 0);
		add_case("bhi_z_nt", br_op(rtf_isa_pkg::BHI, 8'h02), 0, 0, 32'h0, 4'b0111, 0);
		add_case("bls_z_t", br_op(rtf_isa_pkg::BLS, 8'h02), 0, 0, 32'h0, 4'b0111, 2);
		add_case("bge_v_nt", br_op(rtf_isa_pkg::BGE, 8'h02), 0, 0, 32'h0, 4'b0111, 0);
		add_case("blt_v_t", br_op(rtf_isa_pkg::BLT, 8'hfe), 0, 0, 32'h0, 4'b0111, -2);
		add_case("eor_keep_v", rr_op(rtf_isa_pkg::FN_EOR, 13, 5, 1), 1, 13, 32'hffff0000,
			4'b1011, 0);
		// n and v set together
		add_case("bgt_v_t", br_op(rtf_isa_pkg::BGT, 8'h03), 0, 0, 32'h0, 4'b1011, 3);
		add_case("ble_v_nt", br_op(rtf_isa_pkg::BLE, 8'h03), 0, 0, 32'h0, 4'b1011, 0);
		add_idle("idle_1", 4'b1011);
		add_idle("idle_2", 4'b1011);
		add_case("unknown_op", 32'h000010ff, 0, 1, 32'h0, 4'b1011, 0);
		add_case("ld_keep_cv", ld_imm(1, 16'h1234), 1, 1, 32'h00001234, 4'b0011, 0);
		add_case("add_b2b", rr_op(rtf_isa_pkg::FN_ADD, 2, 1, 1), 1, 2, 32'h00002468, 4'b0000, 0);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rst_i        = 1'b1;
		insn_i       = '0;
		insn_valid_i = 1'b0;
		commit_errs  = 0;
		flag_errs    = 0;
		pc_errs      = 0;
		next_pc      = 32'd0;	// matches RESET_PC
		table_len    = 0;
		build_table();
		table_len = cases.size();
		repeat (2) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_pc("reset_pc", 32'd0, pc_o);
		check_flags("reset_flags", 4'b0000, flags_o);
		check_commit("reset_commit", '0, commit_o);
		// an entry driven now commits two edges later
		for (int i = 0; i < table_len + 2; i++) begin
			if (i >= 2) begin
				check_commit(names[i-2], cases[i-2].exp_commit, commit_o);
				check_flags(names[i-2], cases[i-2].exp_flags, flags_o);
				check_pc(names[i-2], cases[i-2].exp_pc, pc_o);
			end
			if (i < table_len) begin
				insn_i       = cases[i].insn;
				insn_valid_i = cases[i].vld;
			end
			else begin
				insn_valid_i = 1'b0;
			end
			@(posedge clk);
			#1;
		end
		$display("error counts: commit %0d, flags %0d, pc %0d", commit_errs, flag_errs, pc_errs);
		if (commit_errs + flag_errs + pc_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog sized from the table length plus slack
	initial begin
		wait (table_len > 0);
		#((table_len + 20) * 4);
		$display("timeout: the run did not end within %0d clock cycles", table_len + 20);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/rtf_isa_pkg.sv
verilog/rtf_core_pkg.sv
verilog/rtf_operand_stage.sv
verilog/rtf_alu.sv
verilog/rtf_branch_eval.sv
verilog/rtf_commit.sv
verilog/rtf_exec_top.sv
dv/rtf_exec_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute slice testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator object directory"
	@echo "  help   list these targets"

test:
	verilator --binary -f src.f --top-module rtf_exec_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vrtf_exec_tb); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
